// ==== source/bridge_pkg.sv ====
package bridge_pkg;

    // bridge window and pages
    localparam logic [7:0]  bridge_base    = 8'hF8; // addr[31:24]
    localparam logic [7:0]  host_page      = 8'h00; // addr[15:8]
    localparam logic [3:0]  datatable_page = 4'h2;  // addr[15:12]

    // host register page offsets
    localparam logic [7:0]  reg_cmd       = 8'h00;
    localparam logic [7:0]  reg_param_ptr = 8'h04;
    localparam logic [7:0]  reg_resp_ptr  = 8'h08;
    localparam logic [7:0]  reg_param0    = 8'h20;
    localparam logic [7:0]  reg_param1    = 8'h24;
    localparam logic [7:0]  reg_param2    = 8'h28;
    localparam logic [7:0]  reg_param3    = 8'h2C;

    localparam logic [31:0] param_ptr_value = 32'h0000_0020;
    localparam logic [31:0] resp_ptr_value  = 32'h0000_0040;

    // upper halves of the command/status word
    localparam logic [15:0] cmd_magic  = 16'h434D; // "CM"
    localparam logic [15:0] busy_magic = 16'h4255; // "BU"
    localparam logic [15:0] done_magic = 16'h4F4B; // "OK"

    typedef logic [15:0] cmd_code_t;

    localparam cmd_code_t cmd_status      = 16'h0000;
    localparam cmd_code_t cmd_reset_enter = 16'h0010;
    localparam cmd_code_t cmd_reset_exit  = 16'h0011;
    localparam cmd_code_t cmd_slot_read   = 16'h0080;
    localparam cmd_code_t cmd_rtc         = 16'h0090;
    localparam cmd_code_t cmd_menu        = 16'h00B0;

    typedef logic [15:0] result_t;

    localparam result_t res_ok        = 16'd0;
    localparam result_t res_booting   = 16'd1;
    localparam result_t res_setup     = 16'd2;
    localparam result_t res_idle      = 16'd3;
    localparam result_t res_running   = 16'd4;
    localparam result_t res_read_fail = 16'd2;  // same value as setup, other command
    localparam result_t res_unknown   = 16'hFFFF;

    localparam int datatable_aw = 10; // 1024 words

endpackage

// ==== source/bridge_endian.sv ====
`timescale 1ns/100ps

module bridge_endian (
    input  logic        clk,
    input  logic        reset,
    input  logic        bridge_endian_little,
    input  logic [31:0] bridge_wr_data,
    input  logic [31:0] rd_data_be,
    output logic [31:0] wr_data_be,
    output logic [31:0] bridge_rd_data
);

    logic [2:0] endian_sync; // three flop synchronizer
    logic       endian_little_s;

    // reverse the four bytes of a word
    function automatic logic [31:0] byte_swap(input logic [31:0] word);
        byte_swap = {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            endian_sync <= 3'b000;
        end else begin
            endian_sync <= {endian_sync[1:0], bridge_endian_little};
        end
    end

    assign endian_little_s = endian_sync[2];

    // internal side is always big-endian
    assign wr_data_be     = endian_little_s ? byte_swap(bridge_wr_data) : bridge_wr_data;
    assign bridge_rd_data = endian_little_s ? byte_swap(rd_data_be) : rd_data_be;

endmodule

// ==== source/bridge_regs.sv ====
`timescale 1ns/100ps

module bridge_regs #(
    parameter int datatable_aw = bridge_pkg::datatable_aw
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             bridge_addr,
    input  logic                    bridge_rd,
    input  logic                    bridge_wr,
    input  logic [31:0]             wr_data_be,
    output logic [31:0]             rd_data_be,
    output logic [datatable_aw-1:0] tbl_addr,
    output logic                    tbl_wren,
    output logic [31:0]             tbl_wr_data,
    input  logic [31:0]             tbl_q,
    output logic                    cmd_valid,
    output bridge_pkg::cmd_code_t   cmd_code,
    input  logic                    cmd_ready,
    output logic [31:0]             param0,
    output logic [31:0]             param1,
    output logic [31:0]             param2,
    input  logic                    status_wr,
    input  logic [31:0]             status_word
);

    import bridge_pkg::*;

    logic        in_window;
    logic        reg_hit;
    logic        tbl_hit;
    logic [7:0]  offset;
    logic        cmd_write;
    logic [31:0] status_reg;   // command/status
    logic [31:0] param3;
    logic [31:0] reg_rd_value;

    // read pipeline, stage 0 after the sampling edge, stage 1 one edge later
    logic        rd_pend_0;
    logic        rd_pend_1;
    logic        rd_tbl_0;
    logic        rd_tbl_1;
    logic [31:0] reg_rd_0;
    logic [31:0] reg_rd_1;

    assign in_window = bridge_addr[31:24] == bridge_base;
    assign reg_hit   = in_window && bridge_addr[15:8] == host_page;
    assign tbl_hit   = in_window && bridge_addr[15:12] == datatable_page;
    assign offset    = bridge_addr[7:0];
    assign cmd_write = bridge_wr && reg_hit && offset == reg_cmd
                       && wr_data_be[31:16] == cmd_magic;

    always_comb begin
        reg_rd_value = '0; // unmapped offsets read zero
        if (reg_hit) begin
            case (offset)
                reg_cmd:       reg_rd_value = status_reg;
                reg_param_ptr: reg_rd_value = param_ptr_value;
                reg_resp_ptr:  reg_rd_value = resp_ptr_value;
                reg_param0:    reg_rd_value = param0;
                reg_param1:    reg_rd_value = param1;
                reg_param2:    reg_rd_value = param2;
                reg_param3:    reg_rd_value = param3;
                default:       reg_rd_value = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_reg <= '0;
            cmd_valid  <= 1'b0;
            tbl_wren   <= 1'b0;
            rd_pend_0  <= 1'b0;
            rd_pend_1  <= 1'b0;
        end else begin
            tbl_wren  <= bridge_wr && tbl_hit;
            rd_pend_0 <= bridge_rd;
            rd_pend_1 <= rd_pend_0;

            // executor write has priority over the host
            if (status_wr) begin
                status_reg <= status_word;
            end else if (bridge_wr && reg_hit && offset == reg_cmd) begin
                status_reg <= wr_data_be;
            end

            if (cmd_write) begin
                cmd_valid <= 1'b1; // a new command overwrites a pending one
            end else if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_write) begin
            cmd_code <= wr_data_be[15:0];
        end
        if (bridge_wr && reg_hit) begin
            case (offset)
                reg_param0: param0 <= wr_data_be;
                reg_param1: param1 <= wr_data_be;
                reg_param2: param2 <= wr_data_be;
                reg_param3: param3 <= wr_data_be;
                default: ;
            endcase
        end

        tbl_addr    <= bridge_addr[datatable_aw+1:2]; // word address
        tbl_wr_data <= wr_data_be;

        rd_tbl_0 <= tbl_hit;
        reg_rd_0 <= reg_rd_value;
        rd_tbl_1 <= rd_tbl_0;
        reg_rd_1 <= reg_rd_0;   // extra stage lines up with the table

        if (rd_pend_1) begin
            rd_data_be <= rd_tbl_1 ? tbl_q : reg_rd_1; // held until next read
        end
    end

    // a pending command only leaves through a handshake with the executor
    assert property (@(posedge clk) disable iff (reset)
        $fell(cmd_valid) |-> $past(cmd_ready));

endmodule

// ==== source/host_cmd_exec.sv ====
`timescale 1ns/100ps

module host_cmd_exec (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  bridge_pkg::cmd_code_t cmd_code,
    output logic                  cmd_ready,
    input  logic [31:0]           param0,
    input  logic [31:0]           param1,
    input  logic [31:0]           param2,
    output logic                  status_wr,
    output logic [31:0]           status_word,
    input  logic                  status_boot_done,
    input  logic                  status_setup_done,
    input  logic                  status_running,
    output logic                  core_reset_n,
    output logic                  slot_read_req,
    output logic [15:0]           slot_read_id,
    input  logic                  slot_read_ack,
    input  logic                  slot_read_ok,
    output logic [31:0]           rtc_epoch_seconds,
    output logic [31:0]           rtc_date_bcd,
    output logic [31:0]           rtc_time_bcd,
    output logic                  rtc_valid,
    output logic                  menu_active
);

    import bridge_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_parse,
        st_done
    } state_t;

    state_t    state;
    cmd_code_t cmd;           // command taken from the register stage
    result_t   result;
    result_t   status_result;

    // status code from the core's state inputs
    always_comb begin
        if (!status_boot_done) begin
            status_result = res_booting;
        end else if (status_setup_done) begin
            status_result = res_idle;
        end else if (status_running) begin
            status_result = res_running;
        end else begin
            status_result = res_setup;
        end
    end

    assign cmd_ready   = state == st_idle;
    assign status_wr   = state != st_idle;
    assign status_word = (state == st_done) ? {done_magic, result} : {busy_magic, cmd};

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_idle;
            core_reset_n  <= 1'b0;  // core held in reset until the host says so
            slot_read_req <= 1'b0;
            rtc_valid     <= 1'b0;
            menu_active   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        cmd   <= cmd_code;
                        state <= st_parse;
                    end
                end
                st_parse: begin
                    state  <= st_done;
                    result <= res_ok;
                    case (cmd)
                        cmd_status: begin
                            result <= status_result;
                        end
                        cmd_reset_enter: begin
                            core_reset_n <= 1'b0;
                        end
                        cmd_reset_exit: begin
                            core_reset_n <= 1'b1;
                        end
                        cmd_slot_read: begin
                            slot_read_id <= param0[15:0];
                            if (slot_read_req && slot_read_ack) begin
                                slot_read_req <= 1'b0;
                                result        <= slot_read_ok ? res_ok : res_read_fail;
                            end else begin
                                slot_read_req <= 1'b1;
                                state         <= st_parse; // wait here for the core
                            end
                        end
                        cmd_rtc: begin
                            rtc_epoch_seconds <= param0;
                            rtc_date_bcd      <= param1;
                            rtc_time_bcd      <= param2;
                            rtc_valid         <= 1'b1;
                        end
                        cmd_menu: begin
                            menu_active <= param0[0];
                        end
                        default: begin
                            result <= res_unknown;
                        end
                    endcase
                end
                st_done: begin
                    state <= st_idle; // done word lands in the status register here
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // the core sees the read request until it answers
    assert property (@(posedge clk) disable iff (reset)
        $fell(slot_read_req) |-> $past(slot_read_ack));

endmodule

// ==== source/datatable_ram.sv ====
`timescale 1ns/100ps

module datatable_ram #(
    parameter int datatable_aw = bridge_pkg::datatable_aw
) (
    input  logic                    clk,
    input  logic [datatable_aw-1:0] a_addr,
    input  logic                    a_wren,
    input  logic [31:0]             a_data,
    output logic [31:0]             a_q,
    input  logic [datatable_aw-1:0] b_addr,
    input  logic                    b_wren,
    input  logic [31:0]             b_data,
    output logic [31:0]             b_q
);

    logic [31:0] mem [2**datatable_aw];

    // both ports write first, so a read returns freshly written data
    always_ff @(posedge clk) begin
        if (a_wren) begin
            mem[a_addr] <= a_data;
            a_q         <= a_data;
        end else begin
            a_q <= mem[a_addr];
        end

        if (b_wren) begin
            mem[b_addr] <= b_data; // port b wins a same-address collision
            b_q         <= b_data;
        end else begin
            b_q <= mem[b_addr];
        end
    end

endmodule

// ==== source/core_bridge_cmd.sv ====
`timescale 1ns/100ps

module core_bridge_cmd #(
    parameter int datatable_aw = bridge_pkg::datatable_aw
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    bridge_endian_little,
    input  logic [31:0]             bridge_addr,
    input  logic                    bridge_rd,
    input  logic                    bridge_wr,
    input  logic [31:0]             bridge_wr_data,
    output logic [31:0]             bridge_rd_data,
    input  logic                    status_boot_done,
    input  logic                    status_setup_done,
    input  logic                    status_running,
    output logic                    core_reset_n,
    output logic                    slot_read_req,
    output logic [15:0]             slot_read_id,
    input  logic                    slot_read_ack,
    input  logic                    slot_read_ok,
    output logic [31:0]             rtc_epoch_seconds,
    output logic [31:0]             rtc_date_bcd,
    output logic [31:0]             rtc_time_bcd,
    output logic                    rtc_valid,
    output logic                    menu_active,
    input  logic [datatable_aw-1:0] datatable_addr,
    input  logic                    datatable_wren,
    input  logic [31:0]             datatable_data,
    output logic [31:0]             datatable_q
);

    logic [31:0]             wr_data_be;
    logic [31:0]             rd_data_be;
    logic [datatable_aw-1:0] tbl_addr;
    logic                    tbl_wren;
    logic [31:0]             tbl_wr_data;
    logic [31:0]             tbl_q;
    logic                    cmd_valid;
    bridge_pkg::cmd_code_t   cmd_code;
    logic                    cmd_ready;
    logic [31:0]             param0;
    logic [31:0]             param1;
    logic [31:0]             param2;
    logic                    status_wr;
    logic [31:0]             status_word;

    bridge_endian i_bridge_endian (
        .clk                  (clk),
        .reset                (reset),
        .bridge_endian_little (bridge_endian_little),
        .bridge_wr_data       (bridge_wr_data),
        .rd_data_be           (rd_data_be),
        .wr_data_be           (wr_data_be),
        .bridge_rd_data       (bridge_rd_data)
    );

    bridge_regs #(
        .datatable_aw (datatable_aw)
    ) i_bridge_regs (
        .clk         (clk),
        .reset       (reset),
        .bridge_addr (bridge_addr),
        .bridge_rd   (bridge_rd),
        .bridge_wr   (bridge_wr),
        .wr_data_be  (wr_data_be),
        .rd_data_be  (rd_data_be),
        .tbl_addr    (tbl_addr),
        .tbl_wren    (tbl_wren),
        .tbl_wr_data (tbl_wr_data),
        .tbl_q       (tbl_q),
        .cmd_valid   (cmd_valid),
        .cmd_code    (cmd_code),
        .cmd_ready   (cmd_ready),
        .param0      (param0),
        .param1      (param1),
        .param2      (param2),
        .status_wr   (status_wr),
        .status_word (status_word)
    );

    host_cmd_exec i_host_cmd_exec (
        .clk               (clk),
        .reset             (reset),
        .cmd_valid         (cmd_valid),
        .cmd_code          (cmd_code),
        .cmd_ready         (cmd_ready),
        .param0            (param0),
        .param1            (param1),
        .param2            (param2),
        .status_wr         (status_wr),
        .status_word       (status_word),
        .status_boot_done  (status_boot_done),
        .status_setup_done (status_setup_done),
        .status_running    (status_running),
        .core_reset_n      (core_reset_n),
        .slot_read_req     (slot_read_req),
        .slot_read_id      (slot_read_id),
        .slot_read_ack     (slot_read_ack),
        .slot_read_ok      (slot_read_ok),
        .rtc_epoch_seconds (rtc_epoch_seconds),
        .rtc_date_bcd      (rtc_date_bcd),
        .rtc_time_bcd      (rtc_time_bcd),
        .rtc_valid         (rtc_valid),
        .menu_active       (menu_active)
    );

    // port a faces the core, port b the bus
    datatable_ram #(
        .datatable_aw (datatable_aw)
    ) i_datatable_ram (
        .clk    (clk),
        .a_addr (datatable_addr),
        .a_wren (datatable_wren),
        .a_data (datatable_data),
        .a_q    (datatable_q),
        .b_addr (tbl_addr),
        .b_wren (tbl_wren),
        .b_data (tbl_wr_data),
        .b_q    (tbl_q)
    );

endmodule

// ==== tb/bridge_ref.svh ====
`ifndef BRIDGE_REF_SVH
`define BRIDGE_REF_SVH

// addresses and data of a back-to-back read sequence
logic [31:0] burst_addr [0:7];
logic [31:0] burst_data [0:7];

function automatic logic [31:0] reg_addr(input logic [7:0] offset);
    reg_addr = {bridge_base, 8'h00, host_page, offset};
endfunction

function automatic logic [31:0] table_addr(input logic [table_aw-1:0] index);
    table_addr = {bridge_base, 8'h00, datatable_page, index, 2'b00}; // word aligned
endfunction

function automatic logic [31:0] swap_bytes(input logic [31:0] word);
    swap_bytes = {word[7:0], word[15:8], word[23:16], word[31:24]};
endfunction

// done word that the host should find once a command has finished
function automatic logic [31:0] expected_status(
    input logic [15:0] code,
    input logic        boot_done,
    input logic        setup_done,
    input logic        running,
    input logic        read_ok
);
    result_t res;
    case (code)
        cmd_status: begin
            if (!boot_done) begin
                res = res_booting;
            end else if (setup_done) begin
                res = res_idle;
            end else if (running) begin
                res = res_running;
            end else begin
                res = res_setup;
            end
        end
        cmd_reset_enter, cmd_reset_exit, cmd_rtc, cmd_menu: begin
            res = res_ok;
        end
        cmd_slot_read: begin
            res = read_ok ? res_ok : res_read_fail;
        end
        default: begin
            res = res_unknown;
        end
    endcase
    expected_status = {done_magic, res};
endfunction

// called just after a rising edge, returns just after the sampling edge
task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(posedge clk);
    #1;
    bridge_wr = 1'b0;
endtask

// one read per cycle, data of read j is valid two edges after its sampling edge
task automatic burst_read(input int count);
    for (int j = 0; j < count + 2; j++) begin
        if (j < count) begin
            bridge_addr = burst_addr[j];
            bridge_rd   = 1'b1;
        end else begin
            bridge_rd = 1'b0;
        end
        @(posedge clk);
        #1;
        if (j >= 2) begin
            burst_data[j - 2] = bridge_rd_data;
        end
    end
endtask

task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data);
    burst_addr[0] = addr;
    burst_read(1);
    data = burst_data[0];
endtask

`endif

// ==== tb/tb_core_bridge_cmd.sv ====
`timescale 1ns/100ps

module tb_core_bridge_cmd;

    import bridge_pkg::*;

    localparam int table_aw = 10;

    logic                clk;
    logic                reset;
    logic                bridge_endian_little;
    logic [31:0]         bridge_addr;
    logic                bridge_rd;
    logic                bridge_wr;
    logic [31:0]         bridge_wr_data;
    logic [31:0]         bridge_rd_data;
    logic                status_boot_done;
    logic                status_setup_done;
    logic                status_running;
    logic                core_reset_n;
    logic                slot_read_req;
    logic [15:0]         slot_read_id;
    logic                slot_read_ack;
    logic                slot_read_ok;
    logic [31:0]         rtc_epoch_seconds;
    logic [31:0]         rtc_date_bcd;
    logic [31:0]         rtc_time_bcd;
    logic                rtc_valid;
    logic                menu_active;
    logic [table_aw-1:0] datatable_addr;
    logic                datatable_wren;
    logic [31:0]         datatable_data;
    logic [31:0]         datatable_q;

    logic [15:0] slot_id_exp;   // id the core model expects while req is high
    logic        slot_ok_given; // ok flag the core model answered with
    int          ack_delay;

    `include "bridge_ref.svh"

    localparam logic [31:0] status_addr = {bridge_base, 8'h00, host_page, reg_cmd};

    core_bridge_cmd #(
        .datatable_aw (table_aw)
    ) i_core_bridge_cmd (.*);

    always #50 clk = ~clk;

    task automatic compare(input string test, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", test, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // command write, then four reads sampled one to four edges after the write
    task automatic issue_command(input string test, input logic [15:0] code,
                                 input logic [31:0] done_word);
        logic [31:0] cmd_word;
        cmd_word = {cmd_magic, code};
        write_word(status_addr, cmd_word);
        for (int k = 0; k < 4; k++) begin
            burst_addr[k] = status_addr;
        end
        burst_read(4);
        compare({test, " echo"}, cmd_word, burst_data[0]);
        compare({test, " echo"}, cmd_word, burst_data[1]);
        compare({test, " busy"}, {busy_magic, code}, burst_data[2]);
        compare({test, " done"}, done_word, burst_data[3]);
    endtask

    task automatic poll_done(output logic [31:0] word);
        int polls;
        polls = 0;
        word  = '0;
        while (word[31:16] !== done_magic) begin
            if (polls == 40) begin
                $display("Timeout: the slot read command never reported its done word");
                $display("Done: errors found");
                $fatal(1, "status poll timed out");
            end else begin
                fetch_word(status_addr, word);
                polls++;
            end
        end
    endtask

    // core model for the slot read request/ack exchange
    initial begin
        logic [31:0] rnd_ok;
        slot_read_ack = 1'b0;
        slot_read_ok  = 1'b0;
        slot_ok_given = 1'b0;
        ack_delay     = -1;
        forever begin
            @(posedge clk);
            #1;
            if (slot_read_ack) begin
                slot_read_ack = 1'b0; // taken by the executor at this edge
            end else if (slot_read_req) begin
                compare("slot read id", {16'h0, slot_id_exp}, {16'h0, slot_read_id});
                if (ack_delay < 0) begin
                    ack_delay = int'($urandom_range(0, 6));
                end else if (ack_delay == 0) begin
                    rnd_ok        = $urandom;
                    slot_read_ok  = rnd_ok[0];
                    slot_ok_given = rnd_ok[0];
                    slot_read_ack = 1'b1;
                    ack_delay     = -1;
                end else begin
                    ack_delay--;
                end
            end
        end
    end

    initial begin
        logic [31:0]         word;
        logic [31:0]         value;
        logic [31:0]         rnd;
        logic [31:0]         p1;
        logic [31:0]         p2;
        logic [15:0]         code;
        logic [table_aw-1:0] base;
        logic [table_aw-1:0] idx;
        logic [31:0]         table_exp [0:7];
        void'($urandom(56));
        clk                  = 1'b0;
        reset                = 1'b1;
        bridge_endian_little = 1'b0;
        bridge_addr          = '0;
        bridge_rd            = 1'b0;
        bridge_wr            = 1'b0;
        bridge_wr_data       = '0;
        status_boot_done     = 1'b0;
        status_setup_done    = 1'b0;
        status_running       = 1'b0;
        datatable_addr       = '0;
        datatable_wren       = 1'b0;
        datatable_data       = '0;
        slot_id_exp          = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        compare("reset outputs", 32'h0,
                {28'h0, core_reset_n, slot_read_req, rtc_valid, menu_active});
        fetch_word(status_addr, word);
        compare("reset status", 32'h0, word);

        // pointers and byte order
        fetch_word(reg_addr(reg_param_ptr), word);
        compare("param pointer", param_ptr_value, word);
        fetch_word(reg_addr(reg_resp_ptr), word);
        compare("resp pointer", resp_ptr_value, word);
        bridge_endian_little = 1'b1;
        repeat (4) @(posedge clk); // through the synchronizer
        #1;
        value = $urandom;
        write_word(reg_addr(reg_param3), value);
        fetch_word(reg_addr(reg_param3), word);
        compare("little endian param", value, word);
        fetch_word(reg_addr(reg_param_ptr), word);
        compare("little endian pointer", swap_bytes(param_ptr_value), word);
        bridge_endian_little = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        fetch_word(reg_addr(reg_param3), word);
        compare("stored byte order", swap_bytes(value), word);

        for (int i = 0; i < 6; i++) begin
            rnd               = $urandom;
            status_boot_done  = rnd[0];
            status_setup_done = rnd[1];
            status_running    = rnd[2];
            issue_command("request status", cmd_status,
                          expected_status(cmd_status, rnd[0], rnd[1], rnd[2], 1'b0));
        end

        issue_command("reset exit", cmd_reset_exit,
                      expected_status(cmd_reset_exit, 1'b0, 1'b0, 1'b0, 1'b0));
        compare("core released", 32'h1, {31'h0, core_reset_n});
        issue_command("reset enter", cmd_reset_enter,
                      expected_status(cmd_reset_enter, 1'b0, 1'b0, 1'b0, 1'b0));
        compare("core held", 32'h0, {31'h0, core_reset_n});
        issue_command("reset exit", cmd_reset_exit,
                      expected_status(cmd_reset_exit, 1'b0, 1'b0, 1'b0, 1'b0));
        compare("core released", 32'h1, {31'h0, core_reset_n});
        rnd  = $urandom;
        code = {1'b1, rnd[14:0]}; // above every defined code
        issue_command("unknown code", code, expected_status(code, 1'b0, 1'b0, 1'b0, 1'b0));

        for (int i = 0; i < 4; i++) begin
            value = $urandom;
            write_word(reg_addr(reg_param0), value);
            slot_id_exp = value[15:0];
            write_word(status_addr, {cmd_magic, cmd_slot_read});
            poll_done(word);
            compare("slot read result",
                    expected_status(cmd_slot_read, 1'b0, 1'b0, 1'b0, slot_ok_given), word);
            compare("slot read request dropped", 32'h0, {31'h0, slot_read_req});
        end

        value = $urandom;
        p1    = $urandom;
        p2    = $urandom;
        write_word(reg_addr(reg_param0), value);
        write_word(reg_addr(reg_param1), p1);
        write_word(reg_addr(reg_param2), p2);
        issue_command("rtc", cmd_rtc, expected_status(cmd_rtc, 1'b0, 1'b0, 1'b0, 1'b0));
        compare("rtc epoch", value, rtc_epoch_seconds);
        compare("rtc date", p1, rtc_date_bcd);
        compare("rtc time", p2, rtc_time_bcd);
        compare("rtc valid", 32'h1, {31'h0, rtc_valid});
        for (int i = 1; i >= 0; i--) begin
            rnd = $urandom;
            write_word(reg_addr(reg_param0), {rnd[31:1], i[0]});
            issue_command("menu notify", cmd_menu,
                          expected_status(cmd_menu, 1'b0, 1'b0, 1'b0, 1'b0));
            compare("menu active", {31'h0, i[0]}, {31'h0, menu_active});
        end

        // data table, core writes read back in order by back-to-back bus reads
        rnd  = $urandom;
        base = rnd[table_aw-1:0];
        idx  = base;
        for (int i = 0; i < 8; i++) begin
            table_exp[i]   = $urandom;
            burst_addr[i]  = table_addr(idx);
            datatable_addr = idx;
            datatable_data = table_exp[i];
            datatable_wren = 1'b1;
            @(posedge clk);
            #1;
            idx = idx + 1'b1;
        end
        datatable_wren = 1'b0;
        burst_read(8);
        for (int i = 0; i < 8; i++) begin
            compare("core write, bus read", table_exp[i], burst_data[i]);
        end
        base = idx;
        for (int i = 0; i < 4; i++) begin
            table_exp[i] = $urandom;
            write_word(table_addr(idx), table_exp[i]);
            idx = idx + 1'b1;
        end
        @(posedge clk); // last bus write reaches the RAM here
        #1;
        idx = base;
        for (int i = 0; i < 4; i++) begin
            datatable_addr = idx;
            @(posedge clk);
            #1;
            compare("bus write, core read", table_exp[i], datatable_q);
            idx = idx + 1'b1;
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+tb
source/bridge_pkg.sv
source/bridge_endian.sv
source/bridge_regs.sv
source/host_cmd_exec.sv
source/datatable_ram.sv
source/core_bridge_cmd.sv
tb/tb_core_bridge_cmd.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core_bridge_cmd
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(wildcard source/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator may exit with an error, the log decides the result
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
